// File: verilog/flash_pkg.sv
package flash_pkg;

    // Bus and flash widths
    localparam int ADDR_W = 32;
    localparam int FLASH_ADDR_W = 24;
    localparam int DATA_W = 64;
    localparam int BYTES_PER_READ = DATA_W / 8;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axil_resp_t;

    // Only the plain single-lane read is supported
    typedef enum logic [7:0] {
        CMD_READ = 8'h03
    } flash_cmd_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_COMMAND,
        ST_DATA
    } reader_state_t;

    // Master to port
    typedef struct packed {
        logic              arvalid;
        logic [ADDR_W-1:0] araddr;
        logic              rready;
        logic              awvalid;
        logic [ADDR_W-1:0] awaddr;
        logic              wvalid;
        logic [DATA_W-1:0] wdata;
        logic [7:0]        wstrb;
        logic              bready;
    } axil_req_t;

    // Port to master
    typedef struct packed {
        logic              arready;
        logic              rvalid;
        logic [DATA_W-1:0] rdata;
        axil_resp_t        rresp;
        logic              awready;
        logic              wready;
        logic              bvalid;
        axil_resp_t        bresp;
    } axil_rsp_t;

endpackage

// File: verilog/flash_reader.sv
`timescale 1ns/1ps

module flash_reader (
    input  logic                            bus,
    input  logic                            rst,

    // Read request from the bus port
    input  logic [flash_pkg::FLASH_ADDR_W-1:0] addr,
    input  logic                            start_read,
    input  logic                            keep_reading,

    // One byte per pulse
    output logic                            data_ready,
    output logic [7:0]                      data,

    // Flash pins
    output logic                            cs,
    output logic                            sclk,
    output logic                            si,
    input  logic                            so,
    output logic                            wp,
    output logic                            hold
);

    flash_pkg::reader_state_t state;

    // Command byte followed by the flash address, sent MSB first
    logic [$bits(flash_pkg::flash_cmd_t)+flash_pkg::FLASH_ADDR_W-1:0] tx_shift;
    logic [7:0] rx_shift;

    // Counts down the bits left in the current word or byte
    logic [4:0] bit_cnt;

    // No write protect or hold in single-lane mode
    assign wp = 1'b1;
    assign hold = 1'b1;

    assign si = tx_shift[$bits(tx_shift)-1];
    assign data = rx_shift;

    // Control state
    always_ff @(posedge bus) begin
        if (rst) begin
            state <= flash_pkg::ST_IDLE;
            cs <= 1'b1;
            sclk <= 1'b0;
            bit_cnt <= '0;
            data_ready <= 1'b0;
        end else begin
            data_ready <= 1'b0;
            case (state)
                flash_pkg::ST_IDLE: begin
                    if (start_read) begin
                        state <= flash_pkg::ST_COMMAND;
                        cs <= 1'b0;
                        bit_cnt <= 5'($bits(tx_shift) - 1);
                    end
                end

                flash_pkg::ST_COMMAND: begin
                    sclk <= !sclk;
                    // Advance on the falling edge, after the flash has sampled si
                    if (sclk) begin
                        if (bit_cnt == '0) begin
                            state <= flash_pkg::ST_DATA;
                            bit_cnt <= 5'd7;
                        end else begin
                            bit_cnt <= bit_cnt - 5'd1;
                        end
                    end
                end

                flash_pkg::ST_DATA: begin
                    sclk <= !sclk;
                    if (!sclk) begin
                        // Last bit of the byte comes in on this rising edge
                        data_ready <= (bit_cnt == '0);
                    end else if (bit_cnt == '0) begin
                        // Byte boundary, either carry on or release the flash
                        if (keep_reading) begin
                            bit_cnt <= 5'd7;
                        end else begin
                            state <= flash_pkg::ST_IDLE;
                            cs <= 1'b1;
                        end
                    end else begin
                        bit_cnt <= bit_cnt - 5'd1;
                    end
                end

                default: begin
                    state <= flash_pkg::ST_IDLE;
                    cs <= 1'b1;
                    sclk <= 1'b0;
                end
            endcase
        end
    end

    // Outgoing shift register, loaded at start and shifted on falling sclk
    always_ff @(posedge bus) begin
        if (state == flash_pkg::ST_IDLE) begin
            if (start_read) begin
                tx_shift <= {flash_pkg::CMD_READ, addr};
            end
        end else if (state == flash_pkg::ST_COMMAND && sclk) begin
            tx_shift <= {tx_shift[$bits(tx_shift)-2:0], 1'b0};
        end
    end

    // so is stable here since the flash only changes it after a falling edge
    always_ff @(posedge bus) begin
        if (state == flash_pkg::ST_DATA && !sclk) begin
            rx_shift <= {rx_shift[6:0], so};
        end
    end

    // The flash must be deselected while the sequencer is idle
    idle_deselects: assert property (
        @(posedge bus) disable iff (rst)
        (state == flash_pkg::ST_IDLE) |-> cs
    );

    start_addr_known: assert property (
        @(posedge bus) disable iff (rst)
        start_read |-> !$isunknown(addr)
    );

endmodule

// File: verilog/axi4lite_flash.sv
`timescale 1ns/1ps

module axi4lite_flash (
    input  logic                               bus,
    input  logic                               rst,

    input  flash_pkg::axil_req_t               req,
    output flash_pkg::axil_rsp_t               rsp,

    // Toward the flash sequencer
    output logic [flash_pkg::FLASH_ADDR_W-1:0] addr,
    output logic                               start_read,
    output logic                               keep_reading,
    input  logic                               data_ready,
    input  logic [7:0]                         data
);

    logic arready;
    logic rvalid;
    logic awready;
    logic wready;
    logic bvalid;

    logic ar_hs;
    logic r_hs;
    logic w_hs;

    // Bytes still to come for the outstanding read
    logic [$clog2(flash_pkg::BYTES_PER_READ+1)-1:0] read_counter;
    logic [flash_pkg::DATA_W-1:0] read_data;
    logic [flash_pkg::DATA_W-1:0] read_merged;

    assign ar_hs = req.arvalid && arready;
    assign r_hs = rvalid && req.rready;
    assign w_hs = req.awvalid && awready && req.wvalid && wready;

    // Reader inputs are combinational so the read starts on the handshake
    assign start_read = ar_hs;
    assign addr = req.araddr[flash_pkg::FLASH_ADDR_W-1:0];
    // More bytes wanted after the one in flight
    assign keep_reading = (read_counter > 1);

    // New byte enters at the top, so the first one ends up least significant
    assign read_merged = {data, read_data[flash_pkg::DATA_W-1:8]};

    always_comb begin
        rsp.arready = arready;
        rsp.rvalid = rvalid;
        rsp.rdata = data_ready ? read_merged : read_data;
        rsp.rresp = flash_pkg::RESP_OKAY;
        rsp.awready = awready;
        rsp.wready = wready;
        rsp.bvalid = bvalid;
        rsp.bresp = flash_pkg::RESP_SLVERR;
    end

    always_ff @(posedge bus) begin
        if (rst) begin
            read_counter <= '0;
        end else if (ar_hs) begin
            read_counter <= $bits(read_counter)'(flash_pkg::BYTES_PER_READ);
        end else if (data_ready) begin
            read_counter <= read_counter - 1'b1;
        end
    end

    always_ff @(posedge bus) begin
        if (data_ready) begin
            read_data <= read_merged;
        end
    end

    // One read at a time, AR closes until the response is taken
    always_ff @(posedge bus) begin
        if (rst) begin
            arready <= 1'b1;
        end else if (ar_hs) begin
            arready <= 1'b0;
        end else if (r_hs) begin
            arready <= 1'b1;
        end
    end

    always_ff @(posedge bus) begin
        if (rst) begin
            rvalid <= 1'b0;
        end else if (r_hs) begin
            rvalid <= 1'b0;
        end else if (data_ready && read_counter == 1) begin
            rvalid <= 1'b1;
        end
    end

    // Writes are never passed to the flash
    always_ff @(posedge bus) begin
        if (rst) begin
            awready <= 1'b0;
            wready <= 1'b0;
            bvalid <= 1'b0;
        end else begin
            // Single-cycle accept pulse, held off while a response is pending
            awready <= req.awvalid && req.wvalid && !awready && !bvalid;
            wready <= req.awvalid && req.wvalid && !wready && !bvalid;
            if (bvalid && req.bready) begin
                bvalid <= 1'b0;
            end else if (w_hs) begin
                bvalid <= 1'b1;
            end
        end
    end

    ar_loads_counter: assert property (
        @(posedge bus) disable iff (rst)
        ar_hs |=> (read_counter != 0)
    );

    // A pending response must not be overwritten by a late byte
    rvalid_no_data: assert property (
        @(posedge bus) disable iff (rst)
        rvalid |=> !data_ready
    );

    bresp_is_error: assert property (
        @(posedge bus) disable iff (rst)
        rsp.bvalid |-> (rsp.bresp == flash_pkg::RESP_SLVERR)
    );

endmodule

// File: verilog/flash_top.sv
`timescale 1ns/1ps

module flash_top (
    input  logic                 bus,
    input  logic                 rst,

    input  flash_pkg::axil_req_t req,
    output flash_pkg::axil_rsp_t rsp,

    // SPI flash pins
    output logic                 cs,
    output logic                 sclk,
    output logic                 si,
    input  logic                 so,
    output logic                 wp,
    output logic                 hold
);

    logic [flash_pkg::FLASH_ADDR_W-1:0] flash_addr;
    logic       start_read;
    logic       keep_reading;
    logic       data_ready;
    logic [7:0] data_byte;

    axi4lite_flash axi4lite_flash_i (
        .bus          (bus),
        .rst          (rst),
        .req          (req),
        .rsp          (rsp),
        .addr         (flash_addr),
        .start_read   (start_read),
        .keep_reading (keep_reading),
        .data_ready   (data_ready),
        .data         (data_byte)
    );

    flash_reader flash_reader_i (
        .bus          (bus),
        .rst          (rst),
        .addr         (flash_addr),
        .start_read   (start_read),
        .keep_reading (keep_reading),
        .data_ready   (data_ready),
        .data         (data_byte),
        .cs           (cs),
        .sclk         (sclk),
        .si           (si),
        .so           (so),
        .wp           (wp),
        .hold         (hold)
    );

endmodule

// File: bench/spi_flash_model.sv
`timescale 1ns/1ps

module spi_flash_model (
    input  logic cs,
    input  logic sclk,
    input  logic si,
    output logic so,
    input  logic wp,
    input  logic hold
);

    // Command byte then 24-bit address, MSB first
    logic [31:0] header;
    int rise_count = 0;

    // Content rule for one flash address
    function automatic logic [7:0] byte_at(input logic [23:0] a);
        return a[7:0] ^ a[15:8] ^ 8'h5A;
    endfunction

    // Read data as one bit stream, MSB of each byte first
    function automatic logic stream_bit(input logic [23:0] start, input int offset);
        logic [7:0] value;
        value = byte_at(start + 24'(offset / 8));
        value = value << (offset % 8);
        return value[7];
    endfunction

    // Deselect ends the transaction
    always @(posedge sclk or posedge cs) begin
        if (cs) begin
            rise_count <= 0;
        end else begin
            if (rise_count < 32) begin
                header <= {header[30:0], si};
            end
            rise_count <= rise_count + 1;
        end
    end

    // New data bit after each falling edge, ready for the next rising one
    always @(negedge sclk or posedge cs) begin
        if (cs) begin
            so <= 1'b0;
        end else if (rise_count >= 32 && header[31:24] == 8'h03 && wp && hold) begin
            so <= stream_bit(header[23:0], rise_count - 32);
        end else begin
            so <= 1'b0;
        end
    end

endmodule

// File: bench/flash_top_tb.sv
`timescale 1ns/1ps

module flash_top_tb;

    localparam int MAX_READS = 40;
    localparam int CYCLES_PER_READ = 300;
    localparam int TIMEOUT_CYCLES = MAX_READS * CYCLES_PER_READ + 2000;
    localparam int RANDOM_READS = 30;
    localparam int STALL_READS = 5;
    localparam int MAX_STALL = 20;

    logic bus;
    logic rst;
    flash_pkg::axil_req_t req;
    flash_pkg::axil_rsp_t rsp;
    logic cs;
    logic sclk;
    logic si;
    logic so;
    logic wp;
    logic hold;

    integer seed;
    int errors = 0;
    int checks = 0;
    int cycle_count = 0;
    logic [63:0] expected_q[$];

    flash_top flash_top_i (
        .bus  (bus),
        .rst  (rst),
        .req  (req),
        .rsp  (rsp),
        .cs   (cs),
        .sclk (sclk),
        .si   (si),
        .so   (so),
        .wp   (wp),
        .hold (hold)
    );

    spi_flash_model flash_model_i (
        .cs   (cs),
        .sclk (sclk),
        .si   (si),
        .so   (so),
        .wp   (wp),
        .hold (hold)
    );

    initial begin
        bus = 1'b0;
        forever begin
            #50 bus = ~bus;
        end
    end

    always @(posedge bus) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("Run timed out after %0d bus cycles without finishing", cycle_count);
        $display("*** TEST FAILED ***");
        $finish;
    end

    // Eight consecutive flash bytes, first one least significant
    function automatic logic [63:0] expected_word(input logic [23:0] addr);
        logic [23:0] a;
        logic [63:0] word;
        word = '0;
        for (int i = 0; i < 8; i++) begin
            a = addr + 24'(i);
            word[8*i +: 8] = a[7:0] ^ a[15:8] ^ 8'h5A;
        end
        return word;
    endfunction

    task automatic check_value(input string what, input logic [63:0] actual,
                               input logic [63:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    // Scoreboard, expected word queued at AR and compared at R
    always @(posedge bus) begin
        if (!rst) begin
            if (req.arvalid && rsp.arready) begin
                expected_q.push_back(expected_word(req.araddr[flash_pkg::FLASH_ADDR_W-1:0]));
            end
            if (rsp.rvalid && req.rready) begin
                if (expected_q.size() == 0) begin
                    errors++;
                    $display("Read response at %0t ns came with no read outstanding", $time);
                end else begin
                    check_value("rdata", rsp.rdata, expected_q.pop_front());
                    check_value("rresp", 64'(rsp.rresp), 64'(flash_pkg::RESP_OKAY));
                end
            end
        end
    end

    task automatic read_word(input logic [31:0] addr, input int stall);
        logic seen;
        logic [63:0] held;
        @(negedge bus);
        req.arvalid = 1'b1;
        req.araddr = addr;
        seen = 1'b0;
        while (!seen) begin
            @(posedge bus);
            seen = rsp.arready;
        end
        @(negedge bus);
        req.arvalid = 1'b0;
        seen = 1'b0;
        while (!seen) begin
            @(posedge bus);
            check_value("arready while read outstanding", 64'(rsp.arready), 64'd0);
            seen = rsp.rvalid;
        end
        held = rsp.rdata;
        repeat (stall) begin
            @(posedge bus);
            check_value("rvalid under stall", 64'(rsp.rvalid), 64'd1);
            check_value("rdata under stall", rsp.rdata, held);
            check_value("arready under stall", 64'(rsp.arready), 64'd0);
        end
        @(negedge bus);
        req.rready = 1'b1;
        @(posedge bus);
        check_value("rdata at handshake", rsp.rdata, held);
        @(negedge bus);
        req.rready = 1'b0;
        check_value("arready after response", 64'(rsp.arready), 64'd1);
    endtask

    task automatic write_rejected(input logic [31:0] addr, input logic [63:0] wdata,
                                  input int bready_delay, input logic watch_cs);
        logic seen;
        @(negedge bus);
        req.awvalid = 1'b1;
        req.awaddr = addr;
        req.wvalid = 1'b1;
        req.wdata = wdata;
        req.wstrb = 8'hFF;
        seen = 1'b0;
        while (!seen) begin
            @(posedge bus);
            if (watch_cs) check_value("cs during write", 64'(cs), 64'd1);
            seen = rsp.awready && rsp.wready;
        end
        @(negedge bus);
        req.awvalid = 1'b0;
        req.wvalid = 1'b0;
        repeat (bready_delay) begin
            @(posedge bus);
            if (watch_cs) check_value("cs during write", 64'(cs), 64'd1);
            check_value("bvalid under stall", 64'(rsp.bvalid), 64'd1);
        end
        @(negedge bus);
        req.bready = 1'b1;
        seen = 1'b0;
        while (!seen) begin
            @(posedge bus);
            if (watch_cs) check_value("cs during write", 64'(cs), 64'd1);
            seen = rsp.bvalid;
        end
        check_value("bresp", 64'(rsp.bresp), 64'(flash_pkg::RESP_SLVERR));
        @(negedge bus);
        req.bready = 1'b0;
    endtask

    initial begin : stimulus
        logic [31:0] addr;
        int stall;
        seed = 32'h251db016;
        rst = 1'b1;
        req = '0;
        repeat (10) @(negedge bus);
        rst = 1'b0;

        // Idle outputs right after reset
        check_value("arready after reset", 64'(rsp.arready), 64'd1);
        check_value("rvalid after reset", 64'(rsp.rvalid), 64'd0);
        check_value("awready after reset", 64'(rsp.awready), 64'd0);
        check_value("wready after reset", 64'(rsp.wready), 64'd0);
        check_value("bvalid after reset", 64'(rsp.bvalid), 64'd0);
        check_value("cs after reset", 64'(cs), 64'd1);
        check_value("sclk after reset", 64'(sclk), 64'd0);
        check_value("wp after reset", 64'(wp), 64'd1);
        check_value("hold after reset", 64'(hold), 64'd1);

        read_word(32'h0000_0100, 0);

        // Upper address bits are ignored by the port
        for (int i = 0; i < RANDOM_READS; i++) begin
            addr = $random(seed);
            read_word(addr, 0);
        end

        for (int i = 0; i < STALL_READS; i++) begin
            addr = $random(seed);
            stall = {$random(seed)} % (MAX_STALL + 1);
            read_word(addr, stall);
        end

        write_rejected(32'h0000_0200, 64'h0123_4567_89AB_CDEF, 3, 1'b1);

        // Write lands while the flash is busy with a read
        fork
            read_word(32'h12AB_CDEF, 2);
            begin
                repeat (20) @(negedge bus);
                write_rejected(32'h0000_0300, 64'hFEDC_BA98_7654_3210, 5, 1'b0);
            end
        join

        $display("Run finished: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: flash_top.f
verilog/flash_pkg.sv
verilog/flash_reader.sv
verilog/axi4lite_flash.sv
verilog/flash_top.sv
bench/spi_flash_model.sv
bench/flash_top_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = flash_top_tb
FILELIST  = flash_top.f
BUILD_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --Mdir $(BUILD_DIR) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf $(BUILD_DIR)
